// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert -j 0
TOP = plotter_tb
FILELIST = sim.f

OBJDIR = obj_dir
BIN = $(OBJDIR)/V$(TOP)
LOG = sim.log
SRCS = $(wildcard rtl/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: rtl/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser (
	input logic clk,
	input logic arst_n,
	output logic rd_trigger,
	input plotter_op_pkg::byte_t rd_data,
	input logic rd_done,
	input logic is_empty,
	output logic wr_trigger,
	output plotter_op_pkg::plot_op_t wr_op,
	input logic is_full,
	output logic cmd_error
);

	localparam int acc_bits = 16;   // holds coord_max * 10 + 9 without wrapping

	typedef enum logic [2:0] {
		ps_kind,
		ps_space,
		ps_x,
		ps_y,
		ps_end,
		ps_write,
		ps_discard
	} parse_state_e;

	parse_state_e state;
	logic rd_pending;
	logic seen_digit;
	logic is_digit;
	logic is_space;
	logic is_lf;
	logic acc_ovf;
	logic [acc_bits-1:0] acc;
	logic [acc_bits-1:0] acc_next;
	plotter_op_pkg::plot_op_t op_q;

	assign is_digit = rd_data >= plotter_op_pkg::ascii_zero && rd_data <= plotter_op_pkg::ascii_nine;
	assign is_space = rd_data == plotter_op_pkg::ascii_space;
	assign is_lf = rd_data == plotter_op_pkg::ascii_lf;

	// the low nibble of an ascii digit is its value
	assign acc_next = acc * acc_bits'(10) + acc_bits'(rd_data[3:0]);
	assign acc_ovf = acc_next > acc_bits'(plotter_cfg_pkg::coord_max);

	// no reads while a finished operation waits for room
	assign rd_trigger = !is_empty && !rd_pending && state != ps_write;
	assign wr_trigger = state == ps_write && !is_full;
	assign wr_op = op_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ps_kind;
			rd_pending <= 1'b0;
			seen_digit <= 1'b0;
			cmd_error <= 1'b0;
		end else begin
			cmd_error <= 1'b0;
			if (rd_trigger) begin
				rd_pending <= 1'b1;
			end else if (rd_done) begin
				rd_pending <= 1'b0;
			end
			if (wr_trigger) begin
				state <= ps_kind;
			end
			if (rd_done) begin
				case (state)
					ps_kind: begin
						if (rd_data == plotter_op_pkg::ascii_m || rd_data == plotter_op_pkg::ascii_d) begin
							state <= ps_space;
						end else if (rd_data == plotter_op_pkg::ascii_h) begin
							state <= ps_end;
						end else if (!is_lf) begin   // blank lines are skipped
							state <= ps_discard;
						end
					end
					ps_space: begin
						seen_digit <= 1'b0;
						if (is_space) begin
							state <= ps_x;
						end else if (is_lf) begin
							cmd_error <= 1'b1;
							state <= ps_kind;
						end else begin
							state <= ps_discard;
						end
					end
					ps_x, ps_y: begin
						if (is_digit) begin
							seen_digit <= 1'b1;
							if (acc_ovf) begin
								state <= ps_discard;   // coordinate too large
							end
						end else if (state == ps_x && is_space && seen_digit) begin
							seen_digit <= 1'b0;
							state <= ps_y;
						end else if (state == ps_y && is_lf && seen_digit) begin
							state <= ps_write;
						end else if (is_lf) begin
							cmd_error <= 1'b1;   // line ended before both coordinates
							state <= ps_kind;
						end else begin
							state <= ps_discard;
						end
					end
					ps_end: state <= is_lf ? ps_write : ps_discard;
					ps_discard: begin
						if (is_lf) begin
							cmd_error <= 1'b1;
							state <= ps_kind;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_done) begin
			case (state)
				ps_kind: begin
					acc <= '0;
					op_q.x <= '0;   // home keeps these at zero
					op_q.y <= '0;
					if (rd_data == plotter_op_pkg::ascii_d) begin
						op_q.kind <= plotter_op_pkg::op_draw;
					end else if (rd_data == plotter_op_pkg::ascii_h) begin
						op_q.kind <= plotter_op_pkg::op_home;
					end else begin
						op_q.kind <= plotter_op_pkg::op_move;
					end
				end
				ps_x: begin
					if (is_digit) begin
						acc <= acc_next;
					end else if (is_space) begin
						op_q.x <= plotter_op_pkg::coord_t'(acc);
						acc <= '0;
					end
				end
				ps_y: begin
					if (is_digit) begin
						acc <= acc_next;
					end else if (is_lf) begin
						op_q.y <= plotter_op_pkg::coord_t'(acc);
					end
				end
				default: ;
			endcase
		end
	end

endmodule : cmd_parser

// File: rtl/fifo_buffer.sv
`timescale 1ns/1ps

module fifo_buffer #(
	parameter int data_bits = $bits(plotter_op_pkg::byte_t),
	parameter int depth_log2 = plotter_cfg_pkg::byte_fifo_depth_log2
) (
	input logic clk,
	input logic arst_n,
	input logic wr_trigger,
	input logic [data_bits-1:0] wr_data,
	input logic rd_trigger,
	output logic [data_bits-1:0] rd_data,
	output logic rd_done,
	output logic is_empty,
	output logic is_full
);

	logic [data_bits-1:0] mem [2**depth_log2];
	logic [depth_log2:0] wr_ptr;   // extra msb tells full from empty
	logic [depth_log2:0] rd_ptr;
	logic [depth_log2-1:0] wr_addr;
	logic [depth_log2-1:0] rd_addr;

	assign wr_addr = wr_ptr[depth_log2-1:0];
	assign rd_addr = rd_ptr[depth_log2-1:0];

	assign is_empty = wr_ptr == rd_ptr;
	assign is_full = wr_ptr[depth_log2] != rd_ptr[depth_log2] && wr_addr == rd_addr;

	// writers check is_full before they strobe
	always_ff @(posedge clk) begin
		if (wr_trigger) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_trigger) begin
			rd_data <= mem[rd_addr];   // valid together with rd_done
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			rd_done <= 1'b0;
		end else begin
			rd_done <= rd_trigger;
			if (wr_trigger) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_trigger) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule : fifo_buffer

// File: rtl/motion_exec.sv
`timescale 1ns/1ps

module motion_exec (
	input logic clk,
	input logic arst_n,
	output logic rd_trigger,
	input plotter_op_pkg::plot_op_t rd_op,
	input logic rd_done,
	input logic is_empty,
	output logic step_x,
	output logic dir_x,
	output logic step_y,
	output logic dir_y,
	output logic pen_down,
	output logic busy
);

	localparam int cnt_bits = $clog2(plotter_cfg_pkg::step_period + 1);
	localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(plotter_cfg_pkg::step_period - 1);

	typedef enum logic [1:0] {
		ms_idle,
		ms_fetch,
		ms_run
	} exec_state_e;

	exec_state_e state;
	logic [cnt_bits-1:0] cnt;
	logic is_home;
	logic off_x;
	logic off_y;
	plotter_op_pkg::coord_t new_x;
	plotter_op_pkg::coord_t new_y;
	plotter_op_pkg::coord_t pos_x;
	plotter_op_pkg::coord_t pos_y;
	plotter_op_pkg::coord_t tgt_x;
	plotter_op_pkg::coord_t tgt_y;

	assign is_home = rd_op.kind == plotter_op_pkg::op_home;
	assign new_x = is_home ? '0 : rd_op.x;
	assign new_y = is_home ? '0 : rd_op.y;

	assign off_x = pos_x != tgt_x;
	assign off_y = pos_y != tgt_y;

	assign rd_trigger = state == ms_idle && !is_empty;   // next op only once idle

	always_ff @(posedge clk) begin
		if (rd_done) begin
			tgt_x <= new_x;
			tgt_y <= new_y;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ms_idle;
			cnt <= '0;
			pos_x <= '0;
			pos_y <= '0;
			step_x <= 1'b0;
			step_y <= 1'b0;
			dir_x <= 1'b0;
			dir_y <= 1'b0;
			pen_down <= 1'b0;
			busy <= 1'b0;
		end else begin
			step_x <= 1'b0;
			step_y <= 1'b0;
			case (state)
				ms_idle: begin
					if (rd_trigger) begin
						state <= ms_fetch;
					end
				end
				ms_fetch: begin
					if (rd_done) begin
						state <= ms_run;
						busy <= 1'b1;
						cnt <= '0;   // first pulse comes step_period cycles after dir settles
						dir_x <= new_x > pos_x;
						dir_y <= new_y > pos_y;
						pen_down <= rd_op.kind == plotter_op_pkg::op_draw;
					end
				end
				ms_run: begin
					if (!off_x && !off_y) begin
						busy <= 1'b0;
						state <= ms_idle;
					end else if (cnt == cnt_last) begin
						cnt <= '0;
						if (off_x) begin
							step_x <= 1'b1;
							pos_x <= dir_x ? pos_x + 1'b1 : pos_x - 1'b1;
						end
						if (off_y) begin   // both axes share the same pacing
							step_y <= 1'b1;
							pos_y <= dir_y ? pos_y + 1'b1 : pos_y - 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= ms_idle;
			endcase
		end
	end

endmodule : motion_exec

// File: rtl/plotter_cfg_pkg.sv
package plotter_cfg_pkg;

	// serial line timing, kept short so simulation stays fast
	localparam int uart_clks_per_bit = 8;   // clock cycles per serial bit

	// buffer sizes as powers of two
	localparam int byte_fifo_depth_log2 = 4;   // 16 characters between receiver and parser
	localparam int op_fifo_depth_log2 = 2;   // 4 decoded operations ahead of the executor

	// motion pacing
	localparam int step_period = 4;   // cycles between two pulses on one axis

	// largest coordinate a command line may carry
	localparam int coord_max = 4095;   // fits the 12-bit position of coord_t

endpackage : plotter_cfg_pkg

// File: rtl/plotter_op_pkg.sv
package plotter_op_pkg;

	typedef logic [7:0] byte_t;   // one received character
	typedef logic [11:0] coord_t;   // position along an axis, in steps

	typedef enum logic [1:0] {
		op_move, // travel with the pen lifted
		op_draw, // travel with the pen on the paper
		op_home // return to 0,0 with the pen lifted
	} op_kind_e;

	// one decoded command line, stored as is in the op FIFO
	typedef struct packed {
		op_kind_e kind;
		coord_t x;
		coord_t y;
	} plot_op_t;

	// characters of the command language
	localparam byte_t ascii_m = "M";
	localparam byte_t ascii_d = "D";
	localparam byte_t ascii_h = "H";
	localparam byte_t ascii_space = " ";
	localparam byte_t ascii_lf = 8'h0a;   // every command ends with a line feed
	localparam byte_t ascii_zero = "0";
	localparam byte_t ascii_nine = "9";

endpackage : plotter_op_pkg

// File: rtl/plotter_top.sv
`timescale 1ns/1ps

module plotter_top (
	input logic clk,
	input logic arst_n,
	input logic uart_rx,
	output logic step_x,
	output logic dir_x,
	output logic step_y,
	output logic dir_y,
	output logic pen_down,
	output logic busy,
	output logic cmd_error,
	output logic rx_overrun
);

	// receiver into the byte FIFO
	logic byte_wr_trigger;
	logic byte_is_full;
	plotter_op_pkg::byte_t byte_wr_data;

	// byte FIFO out to the parser
	logic byte_rd_trigger;
	logic byte_rd_done;
	logic byte_is_empty;
	plotter_op_pkg::byte_t byte_rd_data;

	// parser into the op FIFO
	logic op_wr_trigger;
	logic op_is_full;
	plotter_op_pkg::plot_op_t op_wr;

	// op FIFO out to the executor
	logic op_rd_trigger;
	logic op_rd_done;
	logic op_is_empty;
	plotter_op_pkg::plot_op_t op_rd;

	uart_rx u_uart_rx (
		.clk(clk),
		.arst_n(arst_n),
		.rx(uart_rx),
		.is_full(byte_is_full),
		.wr_trigger(byte_wr_trigger),
		.wr_data(byte_wr_data),
		.rx_overrun(rx_overrun)
	);

	fifo_buffer #(
		.data_bits($bits(plotter_op_pkg::byte_t)),
		.depth_log2(plotter_cfg_pkg::byte_fifo_depth_log2)
	) u_byte_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.wr_trigger(byte_wr_trigger),
		.wr_data(byte_wr_data),
		.rd_trigger(byte_rd_trigger),
		.rd_data(byte_rd_data),
		.rd_done(byte_rd_done),
		.is_empty(byte_is_empty),
		.is_full(byte_is_full)
	);

	cmd_parser u_cmd_parser (
		.clk(clk),
		.arst_n(arst_n),
		.rd_trigger(byte_rd_trigger),
		.rd_data(byte_rd_data),
		.rd_done(byte_rd_done),
		.is_empty(byte_is_empty),
		.wr_trigger(op_wr_trigger),
		.wr_op(op_wr),
		.is_full(op_is_full),
		.cmd_error(cmd_error)
	);

	fifo_buffer #(
		.data_bits($bits(plotter_op_pkg::plot_op_t)),
		.depth_log2(plotter_cfg_pkg::op_fifo_depth_log2)
	) u_op_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.wr_trigger(op_wr_trigger),
		.wr_data(op_wr),
		.rd_trigger(op_rd_trigger),
		.rd_data(op_rd),
		.rd_done(op_rd_done),
		.is_empty(op_is_empty),
		.is_full(op_is_full)
	);

	motion_exec u_motion_exec (
		.clk(clk),
		.arst_n(arst_n),
		.rd_trigger(op_rd_trigger),
		.rd_op(op_rd),
		.rd_done(op_rd_done),
		.is_empty(op_is_empty),
		.step_x(step_x),
		.dir_x(dir_x),
		.step_y(step_y),
		.dir_y(dir_y),
		.pen_down(pen_down),
		.busy(busy)
	);

endmodule : plotter_top

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input logic clk,
	input logic arst_n,
	input logic rx,
	input logic is_full,
	output logic wr_trigger,
	output plotter_op_pkg::byte_t wr_data,
	output logic rx_overrun
);

	localparam int cnt_bits = $clog2(plotter_cfg_pkg::uart_clks_per_bit);
	localparam logic [cnt_bits-1:0] half_bit = cnt_bits'(plotter_cfg_pkg::uart_clks_per_bit / 2 - 1);
	localparam logic [cnt_bits-1:0] full_bit = cnt_bits'(plotter_cfg_pkg::uart_clks_per_bit - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_e;

	rx_state_e state;
	logic [1:0] rx_sync;
	logic rx_s;
	logic [cnt_bits-1:0] cnt;
	logic [2:0] bit_idx;
	logic sample;
	plotter_op_pkg::byte_t shift_q;

	assign rx_s = rx_sync[1];
	assign sample = state == st_data && cnt == full_bit;   // middle of a data bit
	assign wr_data = shift_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_sync <= 2'b11;   // line idles high
		end else begin
			rx_sync <= {rx_sync[0], rx};
		end
	end

	always_ff @(posedge clk) begin
		if (sample) begin
			shift_q <= {rx_s, shift_q[7:1]};   // lsb arrives first
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			cnt <= '0;
			bit_idx <= '0;
			wr_trigger <= 1'b0;
			rx_overrun <= 1'b0;
		end else begin
			wr_trigger <= 1'b0;
			case (state)
				st_idle: begin
					cnt <= '0;
					if (!rx_s) begin
						state <= st_start;
					end
				end
				st_start: begin
					if (cnt == half_bit) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_s ? st_idle : st_data;   // a short glitch is not a start bit
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_data: begin
					if (sample) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= st_stop;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_stop: begin
					if (cnt == full_bit) begin
						state <= st_idle;
						if (rx_s) begin   // framing error drops the byte silently
							if (is_full) begin
								rx_overrun <= 1'b1;   // sticky until reset
							end else begin
								wr_trigger <= 1'b1;
							end
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule : uart_rx

// File: sim.f
rtl/plotter_cfg_pkg.sv
rtl/plotter_op_pkg.sv
rtl/uart_rx.sv
rtl/fifo_buffer.sv
rtl/cmd_parser.sv
rtl/motion_exec.sv
rtl/plotter_top.sv
tests/plotter_sva.sv
tests/plotter_tb.sv

// File: tests/plotter_sva.sv
`timescale 1ns/1ps

module plotter_sva (
	input logic clk,
	input logic arst_n,
	input logic wr_trigger,
	input logic is_full,
	input logic rd_trigger,
	input logic rd_done,
	input logic step_x,
	input logic dir_x,
	input logic step_y,
	input logic dir_y
);

	a_no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
		wr_trigger |-> !is_full) else $error("write strobe while the FIFO is full");

	a_done_after_read: assert property (@(posedge clk) disable iff (!arst_n)
		rd_trigger |=> rd_done) else $error("rd_done missing one cycle after rd_trigger");

	a_one_read_pending: assert property (@(posedge clk) disable iff (!arst_n)
		rd_trigger |=> !rd_trigger) else $error("new read issued before rd_done was seen");

	a_step_x_gap: assert property (@(posedge clk) disable iff (!arst_n)
		step_x |=> !step_x) else $error("step_x on consecutive cycles");

	a_step_y_gap: assert property (@(posedge clk) disable iff (!arst_n)
		step_y |=> !step_y) else $error("step_y on consecutive cycles");

	a_dir_x_settled: assert property (@(posedge clk) disable iff (!arst_n)
		step_x |-> $stable(dir_x)) else $error("dir_x changed right before a step");

	a_dir_y_settled: assert property (@(posedge clk) disable iff (!arst_n)
		step_y |-> $stable(dir_y)) else $error("dir_y changed right before a step");

endmodule : plotter_sva

// step inputs are tied off on the FIFO and the write side on the executor
bind fifo_buffer plotter_sva u_fifo_sva (
	.clk(clk), .arst_n(arst_n), .wr_trigger(wr_trigger), .is_full(is_full),
	.rd_trigger(rd_trigger), .rd_done(rd_done),
	.step_x(1'b0), .dir_x(1'b0), .step_y(1'b0), .dir_y(1'b0)
);

bind motion_exec plotter_sva u_exec_sva (
	.clk(clk), .arst_n(arst_n), .wr_trigger(1'b0), .is_full(1'b0),
	.rd_trigger(rd_trigger), .rd_done(rd_done),
	.step_x(step_x), .dir_x(dir_x), .step_y(step_y), .dir_y(dir_y)
);

// File: tests/plotter_tb.sv
`timescale 1ns/1ps

module plotter_tb;

	localparam int clk_period = 4;
	localparam int bit_clks = plotter_cfg_pkg::uart_clks_per_bit;
	localparam int test_bytes = 120;   // upper bound on the command characters the tests send
	localparam int travel_steps = 6 * 1024;   // sum of the longest legs the tests can request
	localparam int idle_clks = 4000;   // settle windows and reset
	localparam int timeout_ns = 2 * clk_period *
		(test_bytes * 10 * bit_clks + travel_steps * plotter_cfg_pkg::step_period + idle_clks);

	// running totals kept by the step monitor
	typedef struct packed {
		int up_x;
		int dn_x;
		int up_y;
		int dn_y;
		int pen_up;
		int pen_dn;
		int errs;
		int op_full;
	} tally_t;

	logic clk = 1'b0;
	logic arst_n = 1'b0;
	logic uart_rx = 1'b1;
	logic step_x;
	logic dir_x;
	logic step_y;
	logic dir_y;
	logic pen_down;
	logic busy;
	logic cmd_error;
	logic rx_overrun;

	tally_t tally = '0;
	tally_t base;
	tally_t want;
	int model_x = 0;   // position rebuilt from the step pulses
	int model_y = 0;
	int pos_x = 0;   // position the commands should reach
	int pos_y = 0;
	int errors = 0;
	int tests_run = 0;
	logic [31:0] lfsr_state = 32'he78d9187;

	plotter_top u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.uart_rx(uart_rx),
		.step_x(step_x),
		.dir_x(dir_x),
		.step_y(step_y),
		.dir_y(dir_y),
		.pen_down(pen_down),
		.busy(busy),
		.cmd_error(cmd_error),
		.rx_overrun(rx_overrun)
	);

	always #(clk_period / 2) clk = ~clk;

	// outputs are registered on the rising edge, so they are steady here
	always @(negedge clk) begin
		if (step_x) begin
			model_x <= dir_x ? model_x + 1 : model_x - 1;
			if (dir_x) tally.up_x <= tally.up_x + 1;
			else tally.dn_x <= tally.dn_x + 1;
		end
		if (step_y) begin
			model_y <= dir_y ? model_y + 1 : model_y - 1;
			if (dir_y) tally.up_y <= tally.up_y + 1;
			else tally.dn_y <= tally.dn_y + 1;
		end
		if (step_x || step_y) begin
			if (pen_down) tally.pen_dn <= tally.pen_dn + 1;
			else tally.pen_up <= tally.pen_up + 1;
		end
		if (cmd_error) tally.errs <= tally.errs + 1;
		if (u_dut.op_is_full) tally.op_full <= tally.op_full + 1;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic tally_t tally_since(input tally_t now, input tally_t from);
		tally_t d;
		d.up_x = now.up_x - from.up_x;
		d.dn_x = now.dn_x - from.dn_x;
		d.up_y = now.up_y - from.up_y;
		d.dn_y = now.dn_y - from.dn_y;
		d.pen_up = now.pen_up - from.pen_up;
		d.pen_dn = now.pen_dn - from.pen_dn;
		d.errs = now.errs - from.errs;
		d.op_full = now.op_full - from.op_full;
		return d;
	endfunction

	task automatic log_error(input string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	// sends one 8N1 frame starting on a falling edge
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			repeat (bit_clks) @(negedge clk);
		end
	endtask

	task automatic send_string(input string s);
		for (int i = 0; i < s.len(); i++) begin
			send_byte(s[i]);
		end
	endtask

	// quiet means no motion and both FIFOs empty for a while
	task automatic wait_idle();
		int quiet;
		quiet = 0;
		while (quiet < 16) begin
			@(negedge clk);
			if (busy || !u_dut.byte_is_empty || !u_dut.op_is_empty) quiet = 0;
			else quiet++;
		end
	endtask

	task automatic send_and_settle(input string s);
		send_string(s);
		wait_idle();
	endtask

	task automatic start_test();
		base = tally;
		want = '0;
	endtask

	task automatic add_leg(input int tx, input int ty);
		if (tx > pos_x) want.up_x += tx - pos_x;
		else want.dn_x += pos_x - tx;
		if (ty > pos_y) want.up_y += ty - pos_y;
		else want.dn_y += pos_y - ty;
		pos_x = tx;
		pos_y = ty;
	endtask

	task automatic check_tally(input bit pen);
		tally_t got;
		got = tally_since(tally, base);
		if (model_x != pos_x || model_y != pos_y)
			log_error($sformatf("position %0d,%0d, expected %0d,%0d", model_x, model_y, pos_x, pos_y));
		if (got.up_x != want.up_x || got.dn_x != want.dn_x)
			log_error($sformatf("x steps up/down %0d/%0d, expected %0d/%0d",
				got.up_x, got.dn_x, want.up_x, want.dn_x));
		if (got.up_y != want.up_y || got.dn_y != want.dn_y)
			log_error($sformatf("y steps up/down %0d/%0d, expected %0d/%0d",
				got.up_y, got.dn_y, want.up_y, want.dn_y));
		if (got.errs != want.errs)
			log_error($sformatf("%0d cmd_error pulses, expected %0d", got.errs, want.errs));
		if (pen ? got.pen_up != 0 : got.pen_dn != 0)
			log_error($sformatf("%0d steps with the wrong pen level", pen ? got.pen_up : got.pen_dn));
		if (pen_down !== pen)
			log_error($sformatf("pen_down is %b, expected %b", pen_down, pen));
	endtask

	task automatic reset_state_quiet();
		tests_run++;
		start_test();
		if ({step_x, dir_x, step_y, dir_y, pen_down, busy, cmd_error, rx_overrun} !== '0)
			log_error("control output not low after reset");
		repeat (50) @(negedge clk);
		check_tally(1'b0);
	endtask

	task automatic draw_from_home();
		int x;
		int y;
		tests_run++;
		x = rand_bits(10);
		y = rand_bits(10);
		start_test();
		add_leg(x, y);
		send_and_settle($sformatf("D %0d %0d\n", x, y));
		check_tally(1'b1);
	endtask

	task automatic move_both_ways();
		int ax;
		int ay;
		int bx;
		int by;
		tests_run++;
		ax = 512 + rand_bits(9);   // x falls and y rises on the move that follows
		ay = rand_bits(9);
		bx = rand_bits(9);
		by = 512 + rand_bits(9);
		start_test();
		add_leg(ax, ay);
		send_and_settle($sformatf("D %0d %0d\n", ax, ay));
		check_tally(1'b1);
		start_test();
		add_leg(bx, by);
		send_and_settle($sformatf("M %0d %0d\n", bx, by));
		check_tally(1'b0);
	endtask

	task automatic return_home();
		tests_run++;
		start_test();
		add_leg(0, 0);
		send_and_settle("H\n");
		check_tally(1'b0);
	endtask

	task automatic malformed_lines();
		tests_run++;
		start_test();
		want.errs = 2;
		send_string("X 5 5\n");
		send_and_settle("M 4096 7\n");
		check_tally(1'b0);
		start_test();
		add_leg(12, 34);
		send_and_settle("M 12 34\n");
		check_tally(1'b0);
	endtask

	// the long first move keeps the executor busy while the short ones pile up
	task automatic op_fifo_backpressure();
		int tx;
		int ty;
		tests_run++;
		start_test();
		add_leg(700, 700);
		send_string("M 700 700\n");
		for (int i = 0; i < 7; i++) begin
			tx = rand_bits(3);
			ty = rand_bits(3);
			add_leg(tx, ty);
			send_string($sformatf("M %0d %0d\n", tx, ty));
		end
		wait_idle();
		check_tally(1'b0);
		if (tally.op_full == base.op_full)
			log_error("op FIFO never filled during the burst");
		if (rx_overrun)
			log_error("rx_overrun set during the burst");
	endtask

	initial begin
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		reset_state_quiet();
		draw_from_home();
		move_both_ways();
		return_home();
		malformed_lines();
		op_fifo_backpressure();
		$display("tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule : plotter_tb
